// ==== Makefile ====
# Verilator build and run for the PID lock box core

VERILATOR ?= verilator
TOP       ?= tb_pid_controller
FILELIST  ?= pid_controller.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(wildcard design/*.sv) $(wildcard tests/*.sv)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# exit status of the simulator is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

// ==== design/dac_controller.sv ====
`timescale 1ns/100ps

module dac_controller (
	input  logic                clk50,
	input  logic                rst,
	input  pid_pkg::dac_cmd_t   cmd,
	input  logic                cmd_valid,
	output logic                done,      // one cycle after nsync rises
	output pid_pkg::dac_pins_t  dac
);

	typedef enum logic [1:0] {
		ST_REF,    // reference setup frame pending
		ST_IDLE,
		ST_SHIFT,  // frame on the wire
		ST_END     // nsync back high
	} state_t;

	state_t                          state;
	logic [pid_pkg::W_FRAME-1:0]     frame;
	logic [pid_pkg::W_FRAME-1:0]     shreg;      // bits still to send, msb next
	logic [pid_pkg::W_BITCNT-1:0]    cnt;        // clk50 cycles into the frame
	logic                            start;
	logic                            cmd_frame;  // frame came from a command
	logic                            nsync_q;
	logic                            sclk_q;
	logic                            din_q;

	always_comb begin
		// prefix, control, address (msb unused), data, feature
		frame = {4'h0, pid_pkg::DAC_CMD_WRITE, 1'b0, cmd.chan, cmd.data, 4'h0};
		if (state == ST_REF)
			frame = pid_pkg::DAC_REF_FRAME;
		// during done the queue still shows the old command
		start = (state == ST_REF) || (state == ST_IDLE && cmd_valid && !done);
	end

	//////////////////////////////
	// frame fsm
	//////////////////////////////

	// sclk rises with each new din bit, the dac samples on the falling edge
	always_ff @(posedge clk50) begin
		if (rst) begin
			state     <= ST_REF;
			nsync_q   <= 1'b1;
			sclk_q    <= 1'b0;
			din_q     <= 1'b0;
			done      <= 1'b0;
			cmd_frame <= 1'b0;
			cnt       <= '0;
		end else begin
			done <= 1'b0;
			case (state)
				ST_REF, ST_IDLE: begin
					if (start) begin
						nsync_q   <= 1'b0;
						sclk_q    <= 1'b1;  // first rising edge with nsync
						din_q     <= frame[pid_pkg::W_FRAME-1];
						cmd_frame <= (state == ST_IDLE);
						cnt       <= '0;
						state     <= ST_SHIFT;
					end
				end
				ST_SHIFT: begin
					cnt <= cnt + 1'b1;
					if (cnt == '1) begin          // 64th cycle low
						nsync_q <= 1'b1;
						sclk_q  <= 1'b0;
						state   <= ST_END;
					end else if (cnt[0]) begin
						sclk_q <= 1'b1;
						din_q  <= shreg[pid_pkg::W_FRAME-1];
					end else begin
						sclk_q <= 1'b0;             // falling edge, din held
					end
				end
				ST_END: begin
					done  <= cmd_frame;  // reference frame acks nothing
					state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk50) begin
		if (start)
			shreg <= {frame[pid_pkg::W_FRAME-2:0], 1'b0};  // msb already on din
		else if (state == ST_SHIFT && cnt[0] && cnt != '1)
			shreg <= {shreg[pid_pkg::W_FRAME-2:0], 1'b0};
	end

	assign dac = '{nsync: nsync_q, sclk: sclk_q, din: din_q, nldac: 1'b0, nclr: 1'b1};

	// every frame keeps nsync low for 64 clk50 cycles
	a_frame_len: assert property (
		@(posedge clk50) disable iff (rst)
		$fell(nsync_q) |-> ##63 !nsync_q ##1 nsync_q
	);

endmodule

// ==== design/dac_instr_queue.sv ====
`timescale 1ns/100ps

module dac_instr_queue (
	input  logic                                     clk50,
	input  logic                                     rst,
	input  pid_pkg::dac_word_t [pid_pkg::N_LANE-1:0] word,
	input  logic               [pid_pkg::N_LANE-1:0] word_valid,
	output pid_pkg::dac_cmd_t                        cmd,
	output logic                                     cmd_valid,  // level, held until done
	input  logic                                     done        // frame of cmd sent
);

	pid_pkg::dac_word_t [pid_pkg::N_LANE-1:0] slot;     // latest word per lane
	logic               [pid_pkg::N_LANE-1:0] pending;
	logic               [pid_pkg::W_LANE-1:0] rr;       // lane with first claim
	logic               [pid_pkg::W_LANE-1:0] gnt_lane;
	logic                                     gnt_found;
	logic                                     grant;

	// round robin search starting at rr
	always_comb begin
		int idx;
		gnt_found = 1'b0;
		gnt_lane  = '0;
		for (int k = 0; k < pid_pkg::N_LANE; k++) begin
			idx = (int'(rr) + k) % pid_pkg::N_LANE;
			if (!gnt_found && pending[idx]) begin
				gnt_found = 1'b1;
				gnt_lane  = pid_pkg::W_LANE'(idx);
			end
		end
		grant = gnt_found && (!cmd_valid || done);  // free, or freed this cycle
	end

	//////////////////////////////
	// lane slots
	//////////////////////////////

	// the granted slot is freed at grant, a newer word sets it again
	always_ff @(posedge clk50) begin
		if (rst) begin
			pending <= '0;
		end else begin
			for (int l = 0; l < pid_pkg::N_LANE; l++) begin
				if (word_valid[l])
					pending[l] <= 1'b1;
				else if (grant && int'(gnt_lane) == l)
					pending[l] <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk50) begin
		for (int l = 0; l < pid_pkg::N_LANE; l++) begin
			if (word_valid[l])
				slot[l] <= word[l];  // newest wins
		end
	end

	//////////////////////////////
	// command to controller
	//////////////////////////////

	always_ff @(posedge clk50) begin
		if (rst) begin
			cmd_valid <= 1'b0;
			rr        <= '0;
		end else if (grant) begin
			cmd_valid <= 1'b1;
			rr        <= (int'(gnt_lane) == pid_pkg::N_LANE - 1) ? '0 : gnt_lane + 1'b1;
		end else if (done) begin
			cmd_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk50) begin
		if (grant) begin
			cmd.chan <= pid_pkg::W_CHAN'(gnt_lane);  // lane n drives dac channel n
			cmd.data <= slot[gnt_lane];
		end
	end

	a_cmd_stable: assert property (
		@(posedge clk50) disable iff (rst)
		cmd_valid && !done |=> cmd_valid && $stable(cmd)
	);

endmodule

// ==== design/output_preprocessor.sv ====
`timescale 1ns/100ps

module output_preprocessor (
	input  logic              clk50,
	input  logic              rst,
	input  pid_pkg::comp_t    corr,
	input  logic              corr_valid,
	input  pid_pkg::opp_cfg_t cfg,
	input  logic              lock_en,     // loop closed, else no output
	output pid_pkg::dac_word_t word,
	output logic              word_valid
);

	pid_pkg::comp_t     scaled;   // correction times multiplier
	pid_pkg::comp_t     level;    // around out_init, still unclamped
	pid_pkg::dac_word_t clamped;

	//////////////////////////////
	// scale and clamp
	//////////////////////////////

	always_comb begin
		scaled = pid_pkg::comp_t'(cfg.multiplier) * corr;
		level  = pid_pkg::comp_t'(cfg.out_init) + scaled;  // init zero extended
		if (level > pid_pkg::comp_t'(cfg.out_max))
			clamped = cfg.out_max;
		else if (level < pid_pkg::comp_t'(cfg.out_min))
			clamped = cfg.out_min;
		else
			clamped = level[pid_pkg::W_DAC-1:0];  // in range, upper bits are zero
	end

	always_ff @(posedge clk50) begin
		if (rst)
			word_valid <= 1'b0;
		else
			word_valid <= corr_valid && lock_en;
	end

	always_ff @(posedge clk50) begin
		if (corr_valid)
			word <= clamped;
	end

	// word must respect the range that was set when it was computed
	a_word_range: assert property (
		@(posedge clk50) disable iff (rst)
		word_valid && $past(cfg.out_min <= cfg.out_max) |->
			word <= $past(cfg.out_max) && word >= $past(cfg.out_min)
	);

endmodule

// ==== design/oversample_filter.sv ====
`timescale 1ns/100ps

module oversample_filter (
	input  logic                      clk50,
	input  logic                      rst,
	input  pid_pkg::adc_sample_t      sample,
	input  logic                      sample_valid,
	input  logic [pid_pkg::W_OSM-1:0] osm,        // group of 2^osm samples
	output pid_pkg::adc_sample_t      out,
	output logic                      out_valid
);

	logic signed [pid_pkg::W_ACC-1:0] acc;        // sum of the group so far
	logic signed [pid_pkg::W_ACC-1:0] acc_next;   // sum including this sample
	logic        [pid_pkg::OSM_MAX-1:0] cnt;      // samples already in the group
	logic        [pid_pkg::OSM_MAX-1:0] group_last; // 2^osm - 1
	logic                               last;

	always_comb begin
		acc_next   = acc + pid_pkg::W_ACC'(sample);  // sign extended
		group_last = ~('1 << osm);
		last       = (cnt == group_last);
	end

	//////////////////////////////
	// count and accumulate
	//////////////////////////////

	always_ff @(posedge clk50) begin
		if (rst) begin
			acc       <= '0;
			cnt       <= '0;
			out_valid <= 1'b0;
		end else begin
			out_valid <= 1'b0;
			if (sample_valid) begin
				if (last) begin
					acc       <= '0;     // restart group
					cnt       <= '0;
					out_valid <= 1'b1;
				end else begin
					acc <= acc_next;
					cnt <= cnt + 1'b1;
				end
			end
		end
	end

	// average is the group sum shifted down, arithmetic keeps the sign
	always_ff @(posedge clk50) begin
		if (sample_valid && last)
			out <= pid_pkg::adc_sample_t'(acc_next >>> osm);
	end

	// modes above 16 samples would overflow cnt and acc
	a_osm_range: assert property (
		@(posedge clk50) disable iff (rst)
		sample_valid |-> osm <= pid_pkg::OSM_MAX
	);

endmodule

// ==== design/pid_controller.sv ====
`timescale 1ns/100ps

module pid_controller (
	input  logic                        clk50,
	input  logic                        rst,
	input  pid_pkg::adc_sample_t        adc_a,           // lane 0
	input  pid_pkg::adc_sample_t        adc_b,           // lane 1
	input  logic [pid_pkg::N_LANE-1:0]  adc_valid,
	input  pid_pkg::lane_cfg_t          lane_cfg,
	input  logic [pid_pkg::N_LANE-1:0]  lane_update_en,
	input  logic                        cfg_update,      // latch lane_cfg into enabled lanes
	input  logic [pid_pkg::N_LANE-1:0]  lock_en,
	input  logic [pid_pkg::N_LANE-1:0]  pid_clear,
	output pid_pkg::dac_pins_t          dac
);

	pid_pkg::adc_sample_t [pid_pkg::N_LANE-1:0] adc_in;
	pid_pkg::dac_word_t   [pid_pkg::N_LANE-1:0] opp_word;
	logic                 [pid_pkg::N_LANE-1:0] opp_valid;
	pid_pkg::dac_cmd_t                          diq_cmd;
	logic                                       diq_valid;
	logic                                       dac_done;

	assign adc_in = {adc_b, adc_a};

	//////////////////////////////
	// lane chains
	//////////////////////////////

	for (genvar l = 0; l < pid_pkg::N_LANE; l++) begin : g_lane
		pid_pkg::lane_cfg_t   cfg_q;      // this lane's settings
		pid_pkg::adc_sample_t osf_data;
		logic                 osf_valid;
		pid_pkg::comp_t       pid_corr;
		logic                 pid_valid;

		always_ff @(posedge clk50) begin
			if (rst)
				cfg_q <= pid_pkg::LANE_CFG_RESET;
			else if (cfg_update && lane_update_en[l])
				cfg_q <= lane_cfg;
		end

		oversample_filter osf_inst (
			.clk50        (clk50),
			.rst          (rst),
			.sample       (adc_in[l]),
			.sample_valid (adc_valid[l]),
			.osm          (cfg_q.osm),
			.out          (osf_data),
			.out_valid    (osf_valid)
		);

		pid_core pid_inst (
			.clk50        (clk50),
			.rst          (rst),
			.sample       (osf_data),
			.sample_valid (osf_valid),
			.cfg          (cfg_q.pid),
			.clear        (pid_clear[l]),
			.corr         (pid_corr),
			.corr_valid   (pid_valid)
		);

		output_preprocessor opp_inst (
			.clk50      (clk50),
			.rst        (rst),
			.corr       (pid_corr),
			.corr_valid (pid_valid),
			.cfg        (cfg_q.opp),
			.lock_en    (lock_en[l]),
			.word       (opp_word[l]),
			.word_valid (opp_valid[l])
		);
	end

	//////////////////////////////
	// dac path
	//////////////////////////////

	dac_instr_queue dac_iq (
		.clk50      (clk50),
		.rst        (rst),
		.word       (opp_word),
		.word_valid (opp_valid),
		.cmd        (diq_cmd),
		.cmd_valid  (diq_valid),
		.done       (dac_done)
	);

	dac_controller dac_cntrl (
		.clk50     (clk50),
		.rst       (rst),
		.cmd       (diq_cmd),
		.cmd_valid (diq_valid),
		.done      (dac_done),
		.dac       (dac)
	);

endmodule

// ==== design/pid_core.sv ====
`timescale 1ns/100ps

module pid_core (
	input  logic                 clk50,
	input  logic                 rst,
	input  pid_pkg::adc_sample_t sample,
	input  logic                 sample_valid,
	input  pid_pkg::pid_cfg_t    cfg,
	input  logic                 clear,      // zero integral and previous error
	output pid_pkg::comp_t       corr,
	output logic                 corr_valid
);

	pid_pkg::comp_t err;       // setpoint minus sample
	pid_pkg::comp_t err_prev;  // error of the last valid sample
	pid_pkg::comp_t err_sum;   // running integral
	pid_pkg::comp_t sum_next;  // integral including this sample
	pid_pkg::comp_t p_term;
	pid_pkg::comp_t i_term;
	pid_pkg::comp_t d_term;

	//////////////////////////////
	// three terms
	//////////////////////////////

	// all math at full computation width, coefficients sign extended
	always_comb begin
		err      = pid_pkg::comp_t'(cfg.setpoint) - pid_pkg::comp_t'(sample);
		sum_next = err_sum + err;
		p_term   = pid_pkg::comp_t'(cfg.p_coef) * err;
		i_term   = pid_pkg::comp_t'(cfg.i_coef) * sum_next;
		d_term   = pid_pkg::comp_t'(cfg.d_coef) * (err - err_prev); // difference of errors
	end

	//////////////////////////////
	// loop state
	//////////////////////////////

	always_ff @(posedge clk50) begin
		if (rst || clear) begin
			err_sum  <= '0;
			err_prev <= '0;
		end else if (sample_valid) begin
			err_sum  <= sum_next;
			err_prev <= err;
		end
	end

	always_ff @(posedge clk50) begin
		if (rst)
			corr_valid <= 1'b0;
		else
			corr_valid <= sample_valid;  // one cycle behind the filter
	end

	// correction register, one step from sample to output
	always_ff @(posedge clk50) begin
		if (sample_valid)
			corr <= p_term + i_term + d_term;
	end

endmodule

// ==== design/pid_pkg.sv ====
package pid_pkg;

	//////////////////////////////
	// widths
	//////////////////////////////

	localparam int N_LANE   = 2;                 // control loops
	localparam int W_LANE   = $clog2(N_LANE);    // lane index
	localparam int W_ADC    = 18;                // adc sample
	localparam int W_COMP   = 64;                // computation word
	localparam int W_DAC    = 16;                // dac code
	localparam int W_COEF   = 16;                // pid coefficients
	localparam int W_MLT    = 10;                // opp multiplier, sets the largest gain
	localparam int W_OSM    = 3;                 // oversample mode field
	localparam int OSM_MAX  = 4;                 // largest mode, 16 samples per group
	localparam int W_ACC    = W_ADC + OSM_MAX;   // filter accumulator, room for 16 samples
	localparam int W_CHAN   = 3;                 // dac channel address, 8 channels
	localparam int W_FRAME  = 32;                // dac serial frame
	localparam int W_BITCNT = $clog2(2 * W_FRAME); // two clk50 cycles per frame bit

	//////////////////////////////
	// dac frame constants
	//////////////////////////////

	localparam logic [3:0]         DAC_CMD_WRITE = 4'd3;          // write and update one channel
	localparam logic [W_FRAME-1:0] DAC_REF_FRAME = 32'h0800_0001; // internal reference on

	//////////////////////////////
	// types
	//////////////////////////////

	typedef logic signed [W_ADC-1:0]  adc_sample_t;
	typedef logic signed [W_COMP-1:0] comp_t;
	typedef logic        [W_DAC-1:0]  dac_word_t;

	typedef struct packed {
		adc_sample_t              setpoint;
		logic signed [W_COEF-1:0] p_coef;
		logic signed [W_COEF-1:0] i_coef;
		logic signed [W_COEF-1:0] d_coef;
	} pid_cfg_t;

	typedef struct packed {
		dac_word_t               out_max;
		dac_word_t               out_min;
		dac_word_t               out_init;   // output when correction is zero
		logic signed [W_MLT-1:0] multiplier;
	} opp_cfg_t;

	typedef struct packed {
		logic [W_OSM-1:0] osm;
		pid_cfg_t         pid;
		opp_cfg_t         opp;
	} lane_cfg_t;

	typedef struct packed {
		logic [W_CHAN-1:0] chan;
		dac_word_t         data;
	} dac_cmd_t;

	typedef struct packed {
		logic nsync;  // frame select, active low
		logic sclk;
		logic din;
		logic nldac;  // held low, dac updates on each write
		logic nclr;   // held high
	} dac_pins_t;

	// lane config after reset: full output range, unity gain, everything else zero
	localparam lane_cfg_t LANE_CFG_RESET = '{
		osm: '0,
		pid: '0,
		opp: '{out_max: 16'hffff, out_min: 16'h0000, out_init: 16'h0000, multiplier: 10'sd1}
	};

endpackage

// ==== pid_controller.f ====
design/pid_pkg.sv
design/oversample_filter.sv
design/pid_core.sv
design/output_preprocessor.sv
design/dac_instr_queue.sv
design/dac_controller.sv
design/pid_controller.sv
tests/tb_pid_controller.sv

// ==== tests/tb_pid_controller.sv ====
`timescale 1ns/100ps

module tb_pid_controller;

	localparam int FRAME_TIMEOUT = 400;  // clk50 cycles allowed per awaited frame
	localparam int QUIET_CYCLES  = 200;  // window in which no frame may appear

	logic                 clk50;
	logic                 rst;
	pid_pkg::adc_sample_t adc_a;
	pid_pkg::adc_sample_t adc_b;
	logic [1:0]           adc_valid;
	pid_pkg::lane_cfg_t   lane_cfg;
	logic [1:0]           lane_update_en;
	logic                 cfg_update;
	logic [1:0]           lock_en;
	logic [1:0]           pid_clear;
	pid_pkg::dac_pins_t   dac;

	logic [31:0]        frames[$];     // captured dac frames in arrival order
	logic               sclk_prev;
	int                 bit_cnt;
	logic [31:0]        frame_shift;
	longint             err_sum[2];    // model integral per lane
	longint             err_prev[2];   // model previous error per lane
	pid_pkg::lane_cfg_t cfg_model[2];  // settings the model believes each lane holds

	pid_controller uut (
		.clk50          (clk50),
		.rst            (rst),
		.adc_a          (adc_a),
		.adc_b          (adc_b),
		.adc_valid      (adc_valid),
		.lane_cfg       (lane_cfg),
		.lane_update_en (lane_update_en),
		.cfg_update     (cfg_update),
		.lock_en        (lock_en),
		.pid_clear      (pid_clear),
		.dac            (dac)
	);

	initial begin
		clk50 = 1'b0;
		forever #4 clk50 = ~clk50;  // 8 ns period
	end

	//////////////////////////////
	// frame capture
	//////////////////////////////

	// pins change on posedge and have settled by the negedge of clk50
	always @(negedge clk50) begin
		if (dac.nsync) begin
			bit_cnt = 0;  // between frames
		end else if (sclk_prev && !dac.sclk) begin
			frame_shift = {frame_shift[30:0], dac.din};  // msb first
			bit_cnt++;
			if (bit_cnt == 32) begin
				frames.push_back(frame_shift);
				bit_cnt = 0;
			end
		end
		sclk_prev = dac.sclk;
	end

	//////////////////////////////
	// helpers
	//////////////////////////////

	task automatic check_equal(input logic [63:0] got, input logic [63:0] exp, input string what);
		if (got !== exp) begin
			$display("FAILED at time %0t: %s, got 0x%0h expected 0x%0h", $time, what, got, exp);
			$display("TESTBENCH FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic wait_frames(input int count, input string what);
		int cycles;
		cycles = 0;
		while (frames.size() < count) begin
			@(posedge clk50);
			cycles++;
			if (cycles > FRAME_TIMEOUT) begin
				$display("timeout: DAC frame for %s never arrived within %0d cycles", what, cycles);
				$display("TESTBENCH FAILED");
				$fatal(1, "frame timeout");
			end
		end
	endtask

	// prefix 0, write command, 4-bit address, data, feature 0
	function automatic logic [31:0] frame_for(input int chan, input logic [15:0] data);
		return {4'h0, pid_pkg::DAC_CMD_WRITE, 4'(chan), data, 4'h0};
	endfunction

	function automatic pid_pkg::lane_cfg_t make_cfg(input int osm, input int setpoint,
			input int p, input int i, input int d, input int mult,
			input int init, input int lo, input int hi);
		pid_pkg::lane_cfg_t c;
		c.osm            = 3'(osm);
		c.pid.setpoint   = 18'(setpoint);
		c.pid.p_coef     = 16'(p);
		c.pid.i_coef     = 16'(i);
		c.pid.d_coef     = 16'(d);
		c.opp.multiplier = 10'(mult);
		c.opp.out_init   = 16'(init);
		c.opp.out_min    = 16'(lo);
		c.opp.out_max    = 16'(hi);
		return c;
	endfunction

	task automatic configure_lane(input int lane, input pid_pkg::lane_cfg_t c);
		@(negedge clk50);
		lane_cfg       = c;
		lane_update_en = 2'(1 << lane);
		cfg_update     = 1'b1;
		@(negedge clk50);
		cfg_update     = 1'b0;
		lane_update_en = 2'b00;
		cfg_model[lane] = c;
	endtask

	task automatic clear_loops(input logic [1:0] mask);
		@(negedge clk50);
		pid_clear = mask;
		@(negedge clk50);
		pid_clear = 2'b00;
		for (int l = 0; l < 2; l++) begin
			if (mask[l]) begin
				err_sum[l]  = 0;
				err_prev[l] = 0;
			end
		end
	endtask

	task automatic drive_samples(input pid_pkg::adc_sample_t a, input pid_pkg::adc_sample_t b,
			input logic [1:0] valid);
		@(negedge clk50);
		adc_a     = a;
		adc_b     = b;
		adc_valid = valid;
		@(negedge clk50);
		adc_valid = 2'b00;
	endtask

	// loop model turning one filtered sample into the expected dac word
	task automatic predict_word(input int lane, input longint avg, output logic [15:0] word);
		longint             e;
		longint             corr;
		longint             level;
		pid_pkg::lane_cfg_t c;
		c = cfg_model[lane];
		e = longint'(c.pid.setpoint) - avg;
		err_sum[lane] += e;  // integral includes this sample
		corr = longint'(c.pid.p_coef) * e + longint'(c.pid.i_coef) * err_sum[lane]
			+ longint'(c.pid.d_coef) * (e - err_prev[lane]);
		err_prev[lane] = e;
		level = longint'(c.opp.out_init) + longint'(c.opp.multiplier) * corr;
		if (level > longint'(c.opp.out_max))
			word = c.opp.out_max;
		else if (level < longint'(c.opp.out_min))
			word = c.opp.out_min;
		else
			word = level[15:0];
	endtask

	task automatic expect_frame(input int chan, input logic [15:0] word, input string what);
		logic [31:0] f;
		wait_frames(1, what);
		f = frames.pop_front();
		check_equal(f, frame_for(chan, word), what);
	endtask

	//////////////////////////////
	// directed tests
	//////////////////////////////

	task automatic reset_and_reference();
		logic [31:0] f;
		check_equal(dac.nclr, 1'b1, "nclr after reset");
		check_equal(dac.nldac, 1'b0, "nldac after reset");
		check_equal(dac.nsync, 1'b1, "nsync after reset");
		check_equal(dac.sclk, 1'b0, "sclk after reset");
		wait_frames(1, "reference setup");
		f = frames.pop_front();
		check_equal(f, pid_pkg::DAC_REF_FRAME, "reference frame");
	endtask

	task automatic proportional_path();
		int          samples[5] = '{1000, 0, 5000, -3000, 17000};
		logic [15:0] w;
		configure_lane(0, make_cfg(0, 1000, 2, 0, 0, 1, 32768, 0, 65535));
		lock_en[0] = 1'b1;
		foreach (samples[k]) begin
			drive_samples(18'(samples[k]), '0, 2'b01);
			predict_word(0, samples[k], w);
			expect_frame(0, w, "proportional lane 0");
		end
	endtask

	task automatic clamp_limits();
		logic [15:0] w;
		configure_lane(0, make_cfg(0, 0, 1000, 0, 0, 4, 32768, 1000, 60000));
		drive_samples(18'(50000), '0, 2'b01);   // large negative error
		predict_word(0, 50000, w);
		expect_frame(0, 16'd1000, "clamp to out_min");
		drive_samples(-18'sd50000, '0, 2'b01);  // large positive error
		predict_word(0, -50000, w);
		expect_frame(0, 16'd60000, "clamp to out_max");
		drive_samples('0, '0, 2'b01);           // zero error sits at init
		predict_word(0, 0, w);
		expect_frame(0, w, "unclamped init");
	endtask

	// integral follows the average of each four-sample group
	task automatic run_groups(input int groups, input string what);
		int          s;
		longint      sum;
		logic [15:0] w;
		for (int g = 0; g < groups; g++) begin
			sum = 0;
			for (int k = 0; k < 4; k++) begin
				s = int'($urandom % 2001) - 1000;
				sum += s;
				drive_samples('0, 18'(s), 2'b10);
			end
			predict_word(1, sum >>> 2, w);
			expect_frame(1, w, what);
		end
	endtask

	task automatic average_and_integral();
		configure_lane(1, make_cfg(2, 0, 0, 1, 0, 1, 32768, 0, 65535));
		clear_loops(2'b10);
		lock_en[1] = 1'b1;
		run_groups(3, "integral lane 1");
		clear_loops(2'b10);
		run_groups(2, "integral after clear");
	endtask

	task automatic lock_and_merge();
		int          a_val[2] = '{300, -50};
		int          b_val[2] = '{-1000, 400};
		logic [15:0] w0;
		logic [15:0] w1;
		logic [31:0] f0;
		logic [31:0] f1;
		logic        match;
		configure_lane(0, make_cfg(0, 100, 3, 0, 0, 1, 32768, 0, 65535));
		configure_lane(1, make_cfg(0, -200, 1, 0, 2, 2, 30000, 0, 65535));
		clear_loops(2'b11);
		lock_en = 2'b10;  // lane 0 open
		drive_samples(18'(700), '0, 2'b01);
		predict_word(0, 700, w0);  // loop state still advances
		repeat (QUIET_CYCLES) @(negedge clk50);
		check_equal(frames.size(), 0, "frame while lane 0 unlocked");
		lock_en = 2'b11;
		for (int r = 0; r < 2; r++) begin
			drive_samples(18'(a_val[r]), 18'(b_val[r]), 2'b11);
			predict_word(0, a_val[r], w0);
			predict_word(1, b_val[r], w1);
			wait_frames(2, "merged lanes");
			f0 = frames.pop_front();
			f1 = frames.pop_front();
			match = (f0 == frame_for(0, w0) && f1 == frame_for(1, w1))
				|| (f0 == frame_for(1, w1) && f1 == frame_for(0, w0));  // either order
			check_equal(match, 1'b1, "merged frame pair");
		end
	endtask

	//////////////////////////////
	// run
	//////////////////////////////

	initial begin
		void'($urandom(3169));
		rst            = 1'b1;
		adc_a          = '0;
		adc_b          = '0;
		adc_valid      = 2'b00;
		lane_cfg       = '0;
		lane_update_en = 2'b00;
		cfg_update     = 1'b0;
		lock_en        = 2'b00;
		pid_clear      = 2'b00;
		sclk_prev      = 1'b0;
		bit_cnt        = 0;
		frame_shift    = '0;
		for (int l = 0; l < 2; l++) begin
			err_sum[l]   = 0;
			err_prev[l]  = 0;
			cfg_model[l] = pid_pkg::LANE_CFG_RESET;
		end
		repeat (4) @(negedge clk50);
		rst = 1'b0;

		reset_and_reference();
		proportional_path();
		clamp_limits();
		average_and_integral();
		lock_and_merge();

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule
